// File: periph_pkg.sv
// ---------------------------------------------------------------------
// Peripheral bus definitions
// Bus word types, the region map and the timer register layout
// ---------------------------------------------------------------------
package periph_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    typedef enum logic [1:0] {
        region_plic,
        region_timer,
        region_none
    } region_t;

    // Region map, one region per value of the top address byte
    localparam addr_t PlicBase  = 32'h0C00_0000;
    localparam addr_t TimerBase = 32'h1800_0000;
    localparam int    RegionMsb = 31;
    localparam int    RegionLsb = 24;

    // Read data returned for unmapped space
    localparam data_t ErrData = 32'hDEAD_BEEF;

    // Timer channels and their register offsets
    localparam int TimerCount   = 2;
    localparam int TimerStride  = 'h10;
    localparam int TimerCntOff  = 'h0;
    localparam int TimerCtrlOff = 'h4;
    localparam int TimerCmpOff  = 'h8;

endpackage

// File: irq_pkg.sv
// ---------------------------------------------------------------------
// Interrupt definitions
// Source and target counts, priority types and the PLIC register map
// ---------------------------------------------------------------------
package irq_pkg;

    localparam int NumSources  = 4;
    localparam int NumExt      = 2;
    localparam int NumTargets  = 2;
    localparam int MaxPriority = 7;
    localparam int PrioWidth   = $clog2(MaxPriority + 1);

    // Source indices, claim id is index + 1
    localparam int SrcExt0   = 0;
    localparam int SrcExt1   = 1;
    localparam int SrcTimer0 = 2;
    localparam int SrcTimer1 = 3;

    typedef logic [PrioWidth-1:0]              prio_t;
    typedef logic [$clog2(NumSources+1)-1:0]   src_id_t;
    typedef logic [NumSources-1:0]             src_vec_t;
    typedef logic [NumTargets-1:0]             target_vec_t;

    // PLIC register offsets within the region
    localparam int PrioOff      = 'h0000;
    localparam int PrioStride   = 4;
    localparam int PendingOff   = 'h1000;
    localparam int EnableOff    = 'h2000;
    localparam int EnableStride = 'h80;
    localparam int ThreshOff    = 'h20_0000;
    localparam int ThreshStride = 'h1000;
    localparam int ClaimOff     = ThreshOff + 4;

endpackage

// File: periph_decoder.sv
// ---------------------------------------------------------------------
// Peripheral address decoder
// Selects a slave from the region field, muxes read data back and
// answers unmapped space with an error response
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module periph_decoder (
    input  logic              psel_i,
    input  logic              penable_i,
    input  periph_pkg::addr_t paddr_i,
    input  periph_pkg::data_t plic_rdata_i,
    input  periph_pkg::data_t timer_rdata_i,
    output logic              plic_sel_o,
    output logic              timer_sel_o,
    output periph_pkg::data_t prdata_o,
    output logic              pready_o,
    output logic              pslverr_o
);

    logic [periph_pkg::RegionMsb:periph_pkg::RegionLsb] region_field;
    periph_pkg::region_t region;
    logic access;

    assign region_field = paddr_i[periph_pkg::RegionMsb:periph_pkg::RegionLsb];

    always_comb begin
        if (region_field == (periph_pkg::PlicBase >> periph_pkg::RegionLsb)) begin
            region = periph_pkg::region_plic;
        end else if (region_field == (periph_pkg::TimerBase >> periph_pkg::RegionLsb)) begin
            region = periph_pkg::region_timer;
        end else begin
            region = periph_pkg::region_none;
        end
    end

    // No wait states, every access phase completes
    assign access   = psel_i & penable_i;
    assign pready_o = access;

    assign plic_sel_o  = psel_i & (region == periph_pkg::region_plic);
    assign timer_sel_o = psel_i & (region == periph_pkg::region_timer);
    assign pslverr_o   = access & (region == periph_pkg::region_none);

    always_comb begin
        case (region)
            periph_pkg::region_plic:  prdata_o = plic_rdata_i;
            periph_pkg::region_timer: prdata_o = timer_rdata_i;
            default:                  prdata_o = periph_pkg::ErrData;
        endcase
    end

endmodule

// File: periph_timer.sv
// ---------------------------------------------------------------------
// Compare timer
// Free running counters that wrap on a compare match and pulse one
// interrupt per channel
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module periph_timer (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                sel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  periph_pkg::addr_t                   paddr_i,
    input  periph_pkg::data_t                   pwdata_i,
    output periph_pkg::data_t                   rdata_o,
    output logic [periph_pkg::TimerCount-1:0]   timer_irq_o
);

    logic [periph_pkg::RegionLsb-1:0] reg_off;
    logic wr_en;
    periph_pkg::data_t [periph_pkg::TimerCount-1:0] cnt_q;
    periph_pkg::data_t [periph_pkg::TimerCount-1:0] cmp_q;
    logic [periph_pkg::TimerCount-1:0] en_q;
    logic [periph_pkg::TimerCount-1:0] match;

    assign reg_off = paddr_i[periph_pkg::RegionLsb-1:0];
    assign wr_en   = sel_i & penable_i & pwrite_i;

    // Match only counts while the channel runs
    always_comb begin
        for (int ch = 0; ch < periph_pkg::TimerCount; ch++) begin
            match[ch] = en_q[ch] & (cnt_q[ch] == cmp_q[ch]);
        end
    end

    assign timer_irq_o = match;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
            cmp_q <= '0;
            en_q  <= '0;
        end else begin
            for (int ch = 0; ch < periph_pkg::TimerCount; ch++) begin
                // Preset from the bus wins over counting
                if (wr_en && reg_off == ch * periph_pkg::TimerStride + periph_pkg::TimerCntOff) begin
                    cnt_q[ch] <= pwdata_i;
                end else if (match[ch]) begin
                    cnt_q[ch] <= '0;
                end else if (en_q[ch]) begin
                    cnt_q[ch] <= cnt_q[ch] + 1'b1;
                end
                if (wr_en && reg_off == ch * periph_pkg::TimerStride + periph_pkg::TimerCtrlOff) begin
                    en_q[ch] <= pwdata_i[0];
                end
                if (wr_en && reg_off == ch * periph_pkg::TimerStride + periph_pkg::TimerCmpOff) begin
                    cmp_q[ch] <= pwdata_i;
                end
            end
        end
    end

    // Register readback
    always_comb begin
        rdata_o = '0;
        for (int ch = 0; ch < periph_pkg::TimerCount; ch++) begin
            if (reg_off == ch * periph_pkg::TimerStride + periph_pkg::TimerCntOff) begin
                rdata_o = cnt_q[ch];
            end
            if (reg_off == ch * periph_pkg::TimerStride + periph_pkg::TimerCtrlOff) begin
                rdata_o = periph_pkg::data_t'(en_q[ch]);
            end
            if (reg_off == ch * periph_pkg::TimerStride + periph_pkg::TimerCmpOff) begin
                rdata_o = cmp_q[ch];
            end
        end
    end

endmodule

// File: periph_plic.sv
// ---------------------------------------------------------------------
// Platform interrupt controller
// Level gateways, per source priority, per target enable and threshold,
// claim and complete through the claim register
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module periph_plic (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 sel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  periph_pkg::addr_t    paddr_i,
    input  periph_pkg::data_t    pwdata_i,
    input  irq_pkg::src_vec_t    irq_sources_i,
    output periph_pkg::data_t    rdata_o,
    output irq_pkg::target_vec_t irq_o
);

    logic [periph_pkg::RegionLsb-1:0] reg_off;
    logic wr_en;
    logic rd_en;

    irq_pkg::prio_t    [irq_pkg::NumSources-1:0] prio_q;
    irq_pkg::src_vec_t [irq_pkg::NumTargets-1:0] enable_q;
    irq_pkg::prio_t    [irq_pkg::NumTargets-1:0] thresh_q;
    irq_pkg::src_vec_t pending_q;
    irq_pkg::src_vec_t pending_d;
    irq_pkg::src_vec_t in_service_q;
    irq_pkg::src_vec_t in_service_d;
    irq_pkg::src_id_t  [irq_pkg::NumTargets-1:0] best_id;
    irq_pkg::target_vec_t claim_hit;

    assign reg_off = paddr_i[periph_pkg::RegionLsb-1:0];
    assign wr_en   = sel_i & penable_i & pwrite_i;
    assign rd_en   = sel_i & penable_i & ~pwrite_i;

    always_comb begin
        for (int t = 0; t < irq_pkg::NumTargets; t++) begin
            claim_hit[t] = (reg_off == irq_pkg::ClaimOff + irq_pkg::ThreshStride * t);
        end
    end

    // ------------------------------------------------------------------
    // Best candidate per target, ties go to the lowest id
    // ------------------------------------------------------------------
    always_comb begin
        irq_pkg::prio_t best_prio;
        best_id   = '0;
        best_prio = '0;
        for (int t = 0; t < irq_pkg::NumTargets; t++) begin
            best_prio = thresh_q[t];
            for (int s = 0; s < irq_pkg::NumSources; s++) begin
                if (pending_q[s] && enable_q[t][s] && prio_q[s] > best_prio) begin
                    best_prio  = prio_q[s];
                    best_id[t] = irq_pkg::src_id_t'(s + 1);
                end
            end
            irq_o[t] = (best_id[t] != '0);
        end
    end

    // ------------------------------------------------------------------
    // Gateways, claim and complete
    // ------------------------------------------------------------------
    always_comb begin
        pending_d    = pending_q;
        in_service_d = in_service_q;
        for (int s = 0; s < irq_pkg::NumSources; s++) begin
            if (irq_sources_i[s] && !pending_q[s] && !in_service_q[s]) begin
                pending_d[s] = 1'b1;
            end
            for (int t = 0; t < irq_pkg::NumTargets; t++) begin
                if (rd_en && claim_hit[t] && best_id[t] == s + 1) begin
                    pending_d[s]    = 1'b0;
                    in_service_d[s] = 1'b1;
                end
                if (wr_en && claim_hit[t] && pwdata_i == s + 1) begin
                    in_service_d[s] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prio_q       <= '0;
            enable_q     <= '0;
            thresh_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            pending_q    <= pending_d;
            in_service_q <= in_service_d;
            if (wr_en) begin
                for (int s = 0; s < irq_pkg::NumSources; s++) begin
                    if (reg_off == irq_pkg::PrioOff + irq_pkg::PrioStride * s) begin
                        prio_q[s] <= pwdata_i[irq_pkg::PrioWidth-1:0];
                    end
                end
                for (int t = 0; t < irq_pkg::NumTargets; t++) begin
                    if (reg_off == irq_pkg::EnableOff + irq_pkg::EnableStride * t) begin
                        enable_q[t] <= pwdata_i[irq_pkg::NumSources-1:0];
                    end
                    if (reg_off == irq_pkg::ThreshOff + irq_pkg::ThreshStride * t) begin
                        thresh_q[t] <= pwdata_i[irq_pkg::PrioWidth-1:0];
                    end
                end
            end
        end
    end

    // Readback, unmapped offsets return 0
    always_comb begin
        rdata_o = '0;
        for (int s = 0; s < irq_pkg::NumSources; s++) begin
            if (reg_off == irq_pkg::PrioOff + irq_pkg::PrioStride * s) begin
                rdata_o = periph_pkg::data_t'(prio_q[s]);
            end
        end
        if (reg_off == irq_pkg::PendingOff) begin
            rdata_o = periph_pkg::data_t'(pending_q);
        end
        for (int t = 0; t < irq_pkg::NumTargets; t++) begin
            if (reg_off == irq_pkg::EnableOff + irq_pkg::EnableStride * t) begin
                rdata_o = periph_pkg::data_t'(enable_q[t]);
            end
            if (reg_off == irq_pkg::ThreshOff + irq_pkg::ThreshStride * t) begin
                rdata_o = periph_pkg::data_t'(thresh_q[t]);
            end
            if (claim_hit[t]) begin
                rdata_o = periph_pkg::data_t'(best_id[t]);
            end
        end
    end

endmodule

// File: periph_subsystem.sv
// ---------------------------------------------------------------------
// Peripheral subsystem
// Decoder, compare timer and PLIC on one APB register bus
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module periph_subsystem (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  periph_pkg::addr_t            paddr_i,
    input  periph_pkg::data_t            pwdata_i,
    input  logic [irq_pkg::NumExt-1:0]   ext_irq_i,
    output periph_pkg::data_t            prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output irq_pkg::target_vec_t         irq_o
);

    logic plic_sel;
    logic timer_sel;
    periph_pkg::data_t plic_rdata;
    periph_pkg::data_t timer_rdata;
    logic [periph_pkg::TimerCount-1:0] timer_irq;
    irq_pkg::src_vec_t irq_sources;

    // Source vector in source index order
    assign irq_sources[irq_pkg::SrcExt0]   = ext_irq_i[0];
    assign irq_sources[irq_pkg::SrcExt1]   = ext_irq_i[1];
    assign irq_sources[irq_pkg::SrcTimer0] = timer_irq[0];
    assign irq_sources[irq_pkg::SrcTimer1] = timer_irq[1];

    periph_decoder i_decoder (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .paddr_i       ( paddr_i     ),
        .plic_rdata_i  ( plic_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .plic_sel_o    ( plic_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    periph_timer i_timer (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .sel_i       ( timer_sel   ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .rdata_o     ( timer_rdata ),
        .timer_irq_o ( timer_irq   )
    );

    periph_plic i_plic (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .sel_i         ( plic_sel    ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .irq_sources_i ( irq_sources ),
        .rdata_o       ( plic_rdata  ),
        .irq_o         ( irq_o       )
    );

endmodule

// File: tb_periph_subsystem.sv
// ----------------------------------------------------------------------
// Testbench for the peripheral subsystem
// Runs a table of APB accesses, interrupt line changes and interrupt
// waits against the decoder, timer and PLIC
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_periph_subsystem;

    localparam logic [1:0] OpWrite = 2'd0;
    localparam logic [1:0] OpRead  = 2'd1;
    localparam logic [1:0] OpExt   = 2'd2;
    localparam logic [1:0] OpWait  = 2'd3;
    localparam int WaitLimit = 200;
    localparam periph_pkg::addr_t UnmappedBase = 32'h2000_0000;

    typedef struct packed {
        logic [1:0]           op;
        periph_pkg::addr_t    addr;
        periph_pkg::data_t    wdata;
        periph_pkg::data_t    rdata;
        logic                 err;
        logic                 chk_irq;
        irq_pkg::target_vec_t irq;
        logic                 at_most;
    } step_t;

    logic                         clk_i;
    logic                         reset_i;
    logic                         psel_i;
    logic                         penable_i;
    logic                         pwrite_i;
    periph_pkg::addr_t            paddr_i;
    periph_pkg::data_t            pwdata_i;
    logic [irq_pkg::NumExt-1:0]   ext_irq_i;
    periph_pkg::data_t            prdata_o;
    logic                         pready_o;
    logic                         pslverr_o;
    irq_pkg::target_vec_t         irq_o;

    step_t steps_q[$];
    int checks;
    int data_errors;
    int irq_errors;
    int err_errors;
    int timeouts;

    periph_subsystem uut (
        .clk_i     ( clk_i     ),
        .reset_i   ( reset_i   ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .ext_irq_i ( ext_irq_i ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .irq_o     ( irq_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Register addresses
    // ------------------------------------------------------------------
    function automatic periph_pkg::addr_t prio_addr(input int s);
        return periph_pkg::PlicBase + irq_pkg::PrioOff + irq_pkg::PrioStride * s;
    endfunction

    function automatic periph_pkg::addr_t enable_addr(input int t);
        return periph_pkg::PlicBase + irq_pkg::EnableOff + irq_pkg::EnableStride * t;
    endfunction

    function automatic periph_pkg::addr_t thresh_addr(input int t);
        return periph_pkg::PlicBase + irq_pkg::ThreshOff + irq_pkg::ThreshStride * t;
    endfunction

    function automatic periph_pkg::addr_t claim_addr(input int t);
        return thresh_addr(t) + 4;
    endfunction

    function automatic periph_pkg::addr_t timer_addr(input int ch, input int off);
        return periph_pkg::TimerBase + periph_pkg::TimerStride * ch + off;
    endfunction

    // ------------------------------------------------------------------
    // Table entries
    // ------------------------------------------------------------------
    function automatic void write_step(input periph_pkg::addr_t a, input periph_pkg::data_t d,
                                       input logic err);
        steps_q.push_back('{OpWrite, a, d, 32'h0, err, 1'b0, 2'b00, 1'b0});
    endfunction

    function automatic void read_step(input periph_pkg::addr_t a, input periph_pkg::data_t exp,
                                      input logic err, input logic chk,
                                      input irq_pkg::target_vec_t irq, input logic at_most);
        steps_q.push_back('{OpRead, a, 32'h0, exp, err, chk, irq, at_most});
    endfunction

    function automatic void ext_step(input logic [1:0] lines, input irq_pkg::target_vec_t irq);
        steps_q.push_back('{OpExt, 32'h0, 32'(lines), 32'h0, 1'b0, 1'b1, irq, 1'b0});
    endfunction

    function automatic void wait_step(input int target, input irq_pkg::target_vec_t irq);
        steps_q.push_back('{OpWait, 32'h0, 32'(target), 32'h0, 1'b0, 1'b1, irq, 1'b0});
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_data(input string name, input periph_pkg::data_t exp,
                              input periph_pkg::data_t act, input logic at_most);
        checks++;
        if (at_most ? (act > exp) : (act !== exp)) begin
            data_errors++;
            $display("ERROR at %0t ns: %s expected %s%h, got %h", $time, name,
                     at_most ? "at most " : "", exp, act);
        end
    endtask

    task automatic check_irq(input string name, input irq_pkg::target_vec_t exp,
                             input irq_pkg::target_vec_t act);
        checks++;
        if (act !== exp) begin
            irq_errors++;
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            err_errors++;
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------
    // Bus and interrupt drivers
    // ------------------------------------------------------------------
    task automatic apb_transfer(input logic wr, input periph_pkg::addr_t a,
                                input periph_pkg::data_t d, output periph_pkg::data_t rdata,
                                output logic err, output irq_pkg::target_vec_t irq);
        @(posedge clk_i);
        #1;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = a;
        pwdata_i  = d;
        @(posedge clk_i);
        #1;
        penable_i = 1'b1;
        // Sample mid access cycle
        @(negedge clk_i);
        rdata = prdata_o;
        err   = pslverr_o;
        irq   = irq_o;
        check_err("pready_o", 1'b1, pready_o);
        @(posedge clk_i);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic set_ext(input logic [1:0] lines, output irq_pkg::target_vec_t irq);
        @(posedge clk_i);
        #1;
        ext_irq_i = lines;
        @(posedge clk_i);
        @(negedge clk_i);
        irq = irq_o;
    endtask

    task automatic wait_for_irq(input int target, output irq_pkg::target_vec_t irq);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!irq_o[target] && cycles < WaitLimit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!irq_o[target]) begin
            timeouts++;
            $display("Timeout: interrupt target %0d never rose within %0d cycles",
                     target, WaitLimit);
        end
        irq = irq_o;
    endtask

    task automatic apply_steps();
        step_t e;
        periph_pkg::data_t rdata;
        logic err;
        irq_pkg::target_vec_t irq;
        foreach (steps_q[i]) begin
            e = steps_q[i];
            case (e.op)
                OpWrite, OpRead: begin
                    apb_transfer(e.op == OpWrite, e.addr, e.wdata, rdata, err, irq);
                    if (e.op == OpRead) begin
                        check_data("prdata_o", e.rdata, rdata, e.at_most);
                    end
                    check_err("pslverr_o", e.err, err);
                end
                OpExt:   set_ext(e.wdata[1:0], irq);
                default: wait_for_irq(e.wdata, irq);
            endcase
            if (e.chk_irq) begin
                check_irq("irq_o", e.irq, irq);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        irq_pkg::prio_t    prio_v [irq_pkg::NumSources];
        irq_pkg::src_vec_t en_v   [irq_pkg::NumTargets];
        irq_pkg::prio_t    th_v   [irq_pkg::NumTargets];
        periph_pkg::data_t cmp_v  [periph_pkg::TimerCount];
        int total;

        void'($urandom(32'h04957509));
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        ext_irq_i = '0;
        checks = 0;
        data_errors = 0;
        irq_errors = 0;
        err_errors = 0;
        timeouts = 0;

        // Reset state of every register
        for (int s = 0; s < irq_pkg::NumSources; s++) begin
            read_step(prio_addr(s), 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
        end
        read_step(periph_pkg::PlicBase + irq_pkg::PendingOff, 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
        for (int t = 0; t < irq_pkg::NumTargets; t++) begin
            read_step(enable_addr(t), 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
            read_step(thresh_addr(t), 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
            read_step(claim_addr(t), 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
        end
        for (int ch = 0; ch < periph_pkg::TimerCount; ch++) begin
            read_step(timer_addr(ch, periph_pkg::TimerCntOff), 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
            read_step(timer_addr(ch, periph_pkg::TimerCtrlOff), 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
            read_step(timer_addr(ch, periph_pkg::TimerCmpOff), 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);
        end

        // Random readback, masked to field widths
        for (int s = 0; s < irq_pkg::NumSources; s++) begin
            prio_v[s] = irq_pkg::prio_t'($urandom);
            write_step(prio_addr(s), 32'(prio_v[s]), 1'b0);
            read_step(prio_addr(s), 32'(prio_v[s]), 1'b0, 1'b0, 2'b00, 1'b0);
        end
        for (int t = 0; t < irq_pkg::NumTargets; t++) begin
            en_v[t] = irq_pkg::src_vec_t'($urandom);
            th_v[t] = irq_pkg::prio_t'($urandom);
            write_step(enable_addr(t), 32'(en_v[t]), 1'b0);
            read_step(enable_addr(t), 32'(en_v[t]), 1'b0, 1'b0, 2'b00, 1'b0);
            write_step(thresh_addr(t), 32'(th_v[t]), 1'b0);
            read_step(thresh_addr(t), 32'(th_v[t]), 1'b0, 1'b0, 2'b00, 1'b0);
        end
        for (int ch = 0; ch < periph_pkg::TimerCount; ch++) begin
            cmp_v[ch] = $urandom;
            write_step(timer_addr(ch, periph_pkg::TimerCmpOff), cmp_v[ch], 1'b0);
            read_step(timer_addr(ch, periph_pkg::TimerCmpOff), cmp_v[ch], 1'b0, 1'b0, 2'b00, 1'b0);
        end
        // Every pending bit set in the write data
        write_step(periph_pkg::PlicBase + irq_pkg::PendingOff,
                   $urandom | 32'({irq_pkg::NumSources{1'b1}}), 1'b0);
        read_step(periph_pkg::PlicBase + irq_pkg::PendingOff, 32'h0, 1'b0, 1'b1, 2'b00, 1'b0);

        // Unmapped space, same low bits as timer compare 0
        read_step(UnmappedBase, periph_pkg::ErrData, 1'b1, 1'b0, 2'b00, 1'b0);
        write_step(UnmappedBase + periph_pkg::TimerCmpOff, 32'h1234_5678, 1'b1);
        read_step(timer_addr(0, periph_pkg::TimerCmpOff), cmp_v[0], 1'b0, 1'b0, 2'b00, 1'b0);

        // Priority against threshold on target 0
        write_step(prio_addr(irq_pkg::SrcExt0), 32'd5, 1'b0);
        write_step(enable_addr(0), 32'b0001, 1'b0);
        write_step(enable_addr(1), 32'b0000, 1'b0);
        write_step(thresh_addr(0), 32'd2, 1'b0);
        ext_step(2'b01, 2'b01);
        write_step(thresh_addr(0), 32'd5, 1'b0);
        read_step(thresh_addr(0), 32'd5, 1'b0, 1'b1, 2'b00, 1'b0);

        // Claim order by priority, then complete with the line still high
        write_step(prio_addr(irq_pkg::SrcExt0), 32'd3, 1'b0);
        write_step(prio_addr(irq_pkg::SrcExt1), 32'd6, 1'b0);
        write_step(enable_addr(0), 32'b0011, 1'b0);
        write_step(thresh_addr(0), 32'd0, 1'b0);
        ext_step(2'b11, 2'b01);
        read_step(claim_addr(0), 32'd2, 1'b0, 1'b1, 2'b01, 1'b0);
        read_step(claim_addr(0), 32'd1, 1'b0, 1'b1, 2'b01, 1'b0);
        read_step(claim_addr(0), 32'd0, 1'b0, 1'b1, 2'b00, 1'b0);
        write_step(claim_addr(0), 32'd2, 1'b0);
        read_step(claim_addr(0), 32'd2, 1'b0, 1'b1, 2'b01, 1'b0);
        ext_step(2'b00, 2'b00);
        write_step(claim_addr(0), 32'd1, 1'b0);
        write_step(claim_addr(0), 32'd2, 1'b0);

        // Timer channel 0 into target 1
        write_step(timer_addr(0, periph_pkg::TimerCmpOff), 32'd20, 1'b0);
        write_step(prio_addr(irq_pkg::SrcTimer0), 32'd4, 1'b0);
        write_step(enable_addr(1), 32'b0100, 1'b0);
        write_step(thresh_addr(1), 32'd0, 1'b0);
        write_step(timer_addr(0, periph_pkg::TimerCtrlOff), 32'd1, 1'b0);
        wait_step(1, 2'b10);
        read_step(claim_addr(1), 32'd3, 1'b0, 1'b0, 2'b00, 1'b0);
        read_step(timer_addr(0, periph_pkg::TimerCntOff), 32'd20, 1'b0, 1'b0, 2'b00, 1'b1);

        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        @(negedge clk_i);
        check_irq("irq_o", 2'b00, irq_o);
        check_err("pslverr_o", 1'b0, pslverr_o);

        apply_steps();

        total = data_errors + irq_errors + err_errors + timeouts;
        $display("Checks %0d, data errors %0d, irq errors %0d, pslverr errors %0d, timeouts %0d",
                 checks, data_errors, irq_errors, err_errors, timeouts);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
periph_pkg.sv
irq_pkg.sv
periph_decoder.sv
periph_timer.sv
periph_plic.sv
periph_subsystem.sv
tb_periph_subsystem.sv
